// File: files.f
+incdir+design
design/pad_pkg.sv
design/match_pkg.sv
design/pad_reader.sv
design/match_fsm.sv
design/strike_judge.sv
design/fighter_health.sv
design/fight_top.sv
verification/pad_model.sv
verification/tb_fight_top.sv

// File: run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_fight_top \
  -Mdir obj_dir -o tb_fight_top

./obj_dir/tb_fight_top > sim.log 2>&1
cat sim.log

if grep -q -F '** PASS **' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: verification/tb_fight_top.sv
`timescale 1ns/1ns
`include "match_defs.svh"

module tb_fight_top;

  localparam int MAX_ROWS    = 80;
  localparam int IDLE_CYCLES = 3;
  localparam int POLL_CYCLES = 16 * `PAD_HALF_PERIOD;

  // Pressed masks in shift order, A in the MSB
  localparam logic [7:0] BTN_NONE  = 8'h00;
  localparam logic [7:0] BTN_A     = 8'h80;
  localparam logic [7:0] BTN_START = 8'h10;

  // Player 1 stands still, player 2 is either close or far away
  localparam int P1_X   = 100;
  localparam int P1_Y   = 200;
  localparam int NEAR_X = 130;
  localparam int FAR_X  = 300;
  localparam int P2_Y   = 210;

  localparam int ST_START     = int'(match_pkg::STATE_START_SCREEN);
  localparam int ST_PLAYING   = int'(match_pkg::STATE_PLAYING);
  localparam int ST_GAME_OVER = int'(match_pkg::STATE_GAME_OVER);

  logic                   clk_out = 1'b0;
  logic                   arst_n;
  logic                   frame_tick;
  logic [`POS_W-1:0]      p1_x;
  logic [`POS_W-1:0]      p1_y;
  logic [`POS_W-1:0]      p2_x;
  logic [`POS_W-1:0]      p2_y;
  logic                   data1;
  logic                   data2;
  logic [7:0]             pad1_pressed;
  logic [7:0]             pad2_pressed;
  logic                   pad1_stuck;
  logic                   pad2_stuck;
  logic                   latch1;
  logic                   latch2;
  logic                   ctrl_clk1;
  logic                   ctrl_clk2;
  match_pkg::game_state_t game_state;
  logic [`DAMAGE_W-1:0]   damage1;
  logic [`DAMAGE_W-1:0]   damage2;
  logic [`STOCK_W-1:0]    stocks1;
  logic [`STOCK_W-1:0]    stocks2;
  logic                   respawn1;
  logic                   respawn2;
  logic                   hit1;
  logic                   hit2;
  logic                   debug_collision;

  // Stimulus columns
  string      row_name   [MAX_ROWS];
  logic [7:0] row_pat1   [MAX_ROWS];
  logic [7:0] row_pat2   [MAX_ROWS];
  bit         row_stuck1 [MAX_ROWS];
  bit         row_stuck2 [MAX_ROWS];
  int         row_p1x    [MAX_ROWS];
  int         row_p1y    [MAX_ROWS];
  int         row_p2x    [MAX_ROWS];
  int         row_p2y    [MAX_ROWS];
  int         row_ticks  [MAX_ROWS];
  // Expected columns
  int         exp_state    [MAX_ROWS];
  int         exp_damage1  [MAX_ROWS];
  int         exp_damage2  [MAX_ROWS];
  int         exp_stocks1  [MAX_ROWS];
  int         exp_stocks2  [MAX_ROWS];
  int         exp_respawn1 [MAX_ROWS];
  int         exp_respawn2 [MAX_ROWS];
  int         exp_hits1    [MAX_ROWS];
  int         exp_hits2    [MAX_ROWS];
  int         exp_overlap  [MAX_ROWS];
  int         row_count = 0;

  // Reference model, index 0 is player 1
  int m_state;
  int m_damage    [2];
  int m_stocks    [2];
  int m_stun_left [2];
  int m_respawns  [2];
  int m_hits      [2];
  bit m_stunned   [2];
  bit m_a_prev    [2];

  int cycle_count    = 0;
  int timeout_limit  = 1000000;
  int respawn_total1 = 0;
  int respawn_total2 = 0;
  int hit_total1     = 0;
  int hit_total2     = 0;
  int error_count    = 0;
  int row_errors     = 0;
  int tests_run      = 0;
  int tests_failed   = 0;

  always #5 clk_out = ~clk_out;

  fight_top u_fight_top (
    .clk_out         (clk_out),
    .arst_n          (arst_n),
    .data1           (data1),
    .data2           (data2),
    .frame_tick      (frame_tick),
    .p1_x            (p1_x),
    .p1_y            (p1_y),
    .p2_x            (p2_x),
    .p2_y            (p2_y),
    .latch1          (latch1),
    .latch2          (latch2),
    .ctrl_clk1       (ctrl_clk1),
    .ctrl_clk2       (ctrl_clk2),
    .game_state      (game_state),
    .damage1         (damage1),
    .damage2         (damage2),
    .stocks1         (stocks1),
    .stocks2         (stocks2),
    .respawn1        (respawn1),
    .respawn2        (respawn2),
    .hit1            (hit1),
    .hit2            (hit2),
    .debug_collision (debug_collision)
  );

  pad_model u_pad_model1 (
    .latch     (latch1),
    .ctrl_clk  (ctrl_clk1),
    .pressed   (pad1_pressed),
    .stuck_low (pad1_stuck),
    .data      (data1)
  );

  pad_model u_pad_model2 (
    .latch     (latch2),
    .ctrl_clk  (ctrl_clk2),
    .pressed   (pad2_pressed),
    .stuck_low (pad2_stuck),
    .data      (data2)
  );

  // Respawn and hit pulse counters and the run limit
  always @(posedge clk_out) begin
    cycle_count <= cycle_count + 1;
    if (respawn1) begin
      respawn_total1 <= respawn_total1 + 1;
    end
    if (respawn2) begin
      respawn_total2 <= respawn_total2 + 1;
    end
    if (hit1) begin
      hit_total1 <= hit_total1 + 1;
    end
    if (hit2) begin
      hit_total2 <= hit_total2 + 1;
    end
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: the test rows did not finish within %0d cycles", timeout_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_value(input string test_name, input string what,
                             input int expected, input int actual);
    if (expected != actual) begin
      $display("Mismatch %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      error_count++;
      row_errors++;
    end
  endtask

  task automatic add_row(input string name, input logic [7:0] pat1, input bit stuck1,
                         input logic [7:0] pat2, input bit stuck2, input bit apart,
                         input int ticks);
    if (row_count >= MAX_ROWS) begin
      $display("Test table is full, row %s was dropped", name);
      error_count++;
    end else begin
      row_name[row_count]   = name;
      row_pat1[row_count]   = pat1;
      row_stuck1[row_count] = stuck1;
      row_pat2[row_count]   = pat2;
      row_stuck2[row_count] = stuck2;
      row_p1x[row_count]    = P1_X;
      row_p1y[row_count]    = P1_Y;
      row_p2x[row_count]    = apart ? FAR_X : NEAR_X;
      row_p2y[row_count]    = P2_Y;
      row_ticks[row_count]  = ticks;
      row_count++;
    end
  endtask

  task automatic build_table();
    int i;
    add_row("t1_idle_start_screen", BTN_NONE, 1'b0, BTN_NONE, 1'b0, 1'b0, 2);
    add_row("t1_attack_before_start", BTN_A, 1'b0, BTN_A, 1'b0, 1'b0, 3);
    add_row("t2_stuck_pad_no_start", BTN_NONE, 1'b1, BTN_NONE, 1'b0, 1'b0, 2);
    add_row("t2_start_press", BTN_START, 1'b0, BTN_NONE, 1'b0, 1'b0, 1);
    add_row("t3_release", BTN_NONE, 1'b0, BTN_NONE, 1'b0, 1'b0, 1);
    add_row("t3_fresh_hit_both", BTN_A, 1'b0, BTN_A, 1'b0, 1'b0, 1);
    add_row("t3_hold_a", BTN_A, 1'b0, BTN_A, 1'b0, 1'b0, 6);
    add_row("t3_release_apart", BTN_NONE, 1'b0, BTN_NONE, 1'b0, 1'b1, 1);
    add_row("t3_press_apart", BTN_A, 1'b0, BTN_NONE, 1'b0, 1'b1, 2);
    add_row("t4_release", BTN_NONE, 1'b0, BTN_NONE, 1'b0, 1'b0, 1);
    add_row("t4_hit", BTN_A, 1'b0, BTN_NONE, 1'b0, 1'b0, 1);
    add_row("t4_release_short", BTN_NONE, 1'b0, BTN_NONE, 1'b0, 1'b0, 1);
    add_row("t4_press_in_stun", BTN_A, 1'b0, BTN_NONE, 1'b0, 1'b0, 1);
    add_row("t4_release_wait", BTN_NONE, 1'b0, BTN_NONE, 1'b0, 1'b0, 3);
    add_row("t4_press_after_stun", BTN_A, 1'b0, BTN_NONE, 1'b0, 1'b0, 1);
    // Player 2 already has three hits, 24 more use up all stocks
    for (i = 1; i <= 24; i++) begin
      add_row($sformatf("t5_release_%0d", i), BTN_NONE, 1'b0, BTN_NONE, 1'b0, 1'b0, 4);
      add_row($sformatf("t5_hit_%0d", i), BTN_A, 1'b0, BTN_NONE, 1'b0, 1'b0, 1);
    end
    add_row("t6_restart", BTN_NONE, 1'b0, BTN_START, 1'b0, 1'b1, 2);
    add_row("t6_play_resumes", BTN_NONE, 1'b0, BTN_A, 1'b0, 1'b0, 1);
  endtask

  // Offset of fighter 2 from fighter 1 must fall inside the asymmetric box
  function automatic bit boxes_overlap(input int x1, input int y1, input int x2, input int y2);
    int dx;
    int dy;
    dx = x2 - x1;
    dy = y2 - y1;
    return (dx > -`HITBOX_FAR_W) && (dx < `HITBOX_NEAR_W) &&
           (dy > -`HITBOX_FAR_H) && (dy < `HITBOX_NEAR_H);
  endfunction

  task automatic restart_match();
    int f;
    m_state = ST_PLAYING;
    for (f = 0; f < 2; f++) begin
      m_damage[f]    = 0;
      m_stocks[f]    = `STOCKS_INIT;
      m_stunned[f]   = 1'b0;
      m_stun_left[f] = 0;
      m_respawns[f]++;
    end
  endtask

  task automatic update_fighter(input int f, input bit hit);
    if (hit && m_stocks[f] != 0) begin
      m_stunned[f]   = 1'b1;
      m_stun_left[f] = `HITSTUN_FRAMES;
      if (m_damage[f] + `HIT_DAMAGE >= `DAMAGE_LIMIT) begin
        m_damage[f] = 0;
        m_stocks[f]--;
        m_respawns[f]++;
      end else begin
        m_damage[f] += `HIT_DAMAGE;
      end
    end else if (m_stunned[f]) begin
      m_stun_left[f]--;
      if (m_stun_left[f] == 0) begin
        m_stunned[f] = 1'b0;
      end
    end
  endtask

  // Runs the match rules over the whole table and fills the expected columns
  task automatic predict_rows();
    int         r;
    int         t;
    int         limit;
    logic [7:0] raw1;
    logic [7:0] raw2;
    bit         a1;
    bit         a2;
    bit         start_ok;
    bit         ovl;
    bit         hit_on1;
    bit         hit_on2;
    m_state = ST_START;
    limit   = 10;
    for (t = 0; t < 2; t++) begin
      m_damage[t]    = 0;
      m_stocks[t]    = `STOCKS_INIT;
      m_stunned[t]   = 1'b0;
      m_stun_left[t] = 0;
      m_a_prev[t]    = 1'b0;
    end
    for (r = 0; r < row_count; r++) begin
      raw1     = row_stuck1[r] ? 8'h00 : ~row_pat1[r];
      raw2     = row_stuck2[r] ? 8'h00 : ~row_pat2[r];
      a1       = !raw1[7];
      a2       = !raw2[7];
      start_ok = (!raw1[4] && raw1 != 8'h00) || (!raw2[4] && raw2 != 8'h00);
      ovl      = boxes_overlap(row_p1x[r], row_p1y[r], row_p2x[r], row_p2y[r]);
      m_respawns[0] = 0;
      m_respawns[1] = 0;
      m_hits[0]     = 0;
      m_hits[1]     = 0;
      if (m_state != ST_PLAYING && start_ok) begin
        restart_match();
      end
      for (t = 0; t < row_ticks[r]; t++) begin
        if (m_state == ST_PLAYING) begin
          // Each fighter is struck by the other's fresh A press
          hit_on1 = a2 && !m_a_prev[1] && ovl && !m_stunned[0];
          hit_on2 = a1 && !m_a_prev[0] && ovl && !m_stunned[1];
          if (hit_on1) begin
            m_hits[0]++;
          end
          if (hit_on2) begin
            m_hits[1]++;
          end
          update_fighter(0, hit_on1);
          update_fighter(1, hit_on2);
          m_a_prev[0] = a1;
          m_a_prev[1] = a2;
          if (m_stocks[0] == 0 || m_stocks[1] == 0) begin
            m_state = ST_GAME_OVER;
            if (start_ok) begin
              restart_match();
            end
          end
        end
      end
      exp_state[r]    = m_state;
      exp_damage1[r]  = m_damage[0];
      exp_damage2[r]  = m_damage[1];
      exp_stocks1[r]  = m_stocks[0];
      exp_stocks2[r]  = m_stocks[1];
      exp_respawn1[r] = m_respawns[0];
      exp_respawn2[r] = m_respawns[1];
      exp_hits1[r]    = m_hits[0];
      exp_hits2[r]    = m_hits[1];
      exp_overlap[r]  = int'(ovl);
      limit += (row_ticks[r] + 2) * POLL_CYCLES * 2;
    end
    timeout_limit = limit;
  endtask

  task automatic report_row(input string name);
    tests_run++;
    if (row_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d mismatches", name, row_errors);
    end
  endtask

  task automatic check_reset_values();
    row_errors = 0;
    check_value("after_reset", "state", ST_START, int'(game_state));
    check_value("after_reset", "damage1", 0, int'(damage1));
    check_value("after_reset", "damage2", 0, int'(damage2));
    check_value("after_reset", "stocks1", `STOCKS_INIT, int'(stocks1));
    check_value("after_reset", "stocks2", `STOCKS_INIT, int'(stocks2));
    check_value("after_reset", "latch1", 0, int'(latch1));
    check_value("after_reset", "latch2", 0, int'(latch2));
    check_value("after_reset", "ctrl_clk1", 0, int'(ctrl_clk1));
    check_value("after_reset", "ctrl_clk2", 0, int'(ctrl_clk2));
    report_row("after_reset");
  endtask

  task automatic pulse_frame();
    frame_tick = 1'b1;
    @(posedge clk_out);
    #1;
    frame_tick = 1'b0;
    repeat (IDLE_CYCLES) @(posedge clk_out);
    #1;
  endtask

  task automatic run_row(input int r);
    int base1;
    int base2;
    int hit_base1;
    int hit_base2;
    int t;
    row_errors   = 0;
    base1        = respawn_total1;
    base2        = respawn_total2;
    hit_base1    = hit_total1;
    hit_base2    = hit_total2;
    pad1_pressed = row_pat1[r];
    pad1_stuck   = row_stuck1[r];
    pad2_pressed = row_pat2[r];
    pad2_stuck   = row_stuck2[r];
    p1_x         = `POS_W'(row_p1x[r]);
    p1_y         = `POS_W'(row_p1y[r]);
    p2_x         = `POS_W'(row_p2x[r]);
    p2_y         = `POS_W'(row_p2y[r]);
    // The second poll start means one whole poll saw the new pattern
    repeat (2) @(posedge latch1);
    @(posedge clk_out);
    #1;
    for (t = 0; t < row_ticks[r]; t++) begin
      pulse_frame();
    end
    repeat (2) @(posedge clk_out);
    #1;
    check_value(row_name[r], "state", exp_state[r], int'(game_state));
    check_value(row_name[r], "damage1", exp_damage1[r], int'(damage1));
    check_value(row_name[r], "damage2", exp_damage2[r], int'(damage2));
    check_value(row_name[r], "stocks1", exp_stocks1[r], int'(stocks1));
    check_value(row_name[r], "stocks2", exp_stocks2[r], int'(stocks2));
    check_value(row_name[r], "respawn1", exp_respawn1[r], respawn_total1 - base1);
    check_value(row_name[r], "respawn2", exp_respawn2[r], respawn_total2 - base2);
    check_value(row_name[r], "hit1", exp_hits1[r], hit_total1 - hit_base1);
    check_value(row_name[r], "hit2", exp_hits2[r], hit_total2 - hit_base2);
    check_value(row_name[r], "overlap", exp_overlap[r], int'(debug_collision));
    report_row(row_name[r]);
  endtask

  initial begin
    int r;
    arst_n       = 1'b0;
    frame_tick   = 1'b0;
    pad1_pressed = BTN_NONE;
    pad2_pressed = BTN_NONE;
    pad1_stuck   = 1'b0;
    pad2_stuck   = 1'b0;
    p1_x         = `POS_W'(P1_X);
    p1_y         = `POS_W'(P1_Y);
    p2_x         = `POS_W'(FAR_X);
    p2_y         = `POS_W'(P2_Y);
    build_table();
    predict_rows();
    repeat (10) @(posedge clk_out);
    #1;
    arst_n = 1'b1;
    check_reset_values();
    for (r = 0; r < row_count; r++) begin
      run_row(r);
    end
    $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: verification/pad_model.sv
`timescale 1ns/1ns

module pad_model (
  input  logic       latch,
  input  logic       ctrl_clk,
  input  logic [7:0] pressed,
  input  logic       stuck_low,
  output logic       data
);

  // Active-low button byte, A leaves first
  logic [7:0] shift_q = 8'hFF;
  // Short to ground, taken once per poll
  logic       stuck_q = 1'b0;

  // Parallel load on latch, then one bit per clock pulse
  always @(posedge latch or posedge ctrl_clk) begin
    if (latch) begin
      shift_q <= ~pressed;
      stuck_q <= stuck_low;
    end else begin
      // Open serial input reads as released
      shift_q <= {shift_q[6:0], 1'b1};
    end
  end

  // A shorted line reads as every button held
  assign data = stuck_q ? 1'b0 : shift_q[7];

endmodule

// File: design/fight_top.sv
`timescale 1ns/1ns
`include "match_defs.svh"

module fight_top (
  input  logic                   clk_out,
  input  logic                   arst_n,
  input  logic                   data1,
  input  logic                   data2,
  input  logic                   frame_tick,
  input  logic [`POS_W-1:0]      p1_x,
  input  logic [`POS_W-1:0]      p1_y,
  input  logic [`POS_W-1:0]      p2_x,
  input  logic [`POS_W-1:0]      p2_y,
  output logic                   latch1,
  output logic                   latch2,
  output logic                   ctrl_clk1,
  output logic                   ctrl_clk2,
  output match_pkg::game_state_t game_state,
  output logic [`DAMAGE_W-1:0]   damage1,
  output logic [`DAMAGE_W-1:0]   damage2,
  output logic [`STOCK_W-1:0]    stocks1,
  output logic [`STOCK_W-1:0]    stocks2,
  output logic                   respawn1,
  output logic                   respawn2,
  output logic                   hit1,
  output logic                   hit2,
  output logic                   debug_collision
);

  pad_pkg::pad_word_t pad1;
  pad_pkg::pad_word_t pad2;
  logic               play_tick;
  logic               game_start;
  logic               stunned1;
  logic               stunned2;

  pad_reader u_pad1 (
    .clk_out  (clk_out),
    .arst_n   (arst_n),
    .data     (data1),
    .latch    (latch1),
    .ctrl_clk (ctrl_clk1),
    .pad      (pad1)
  );

  pad_reader u_pad2 (
    .clk_out  (clk_out),
    .arst_n   (arst_n),
    .data     (data2),
    .latch    (latch2),
    .ctrl_clk (ctrl_clk2),
    .pad      (pad2)
  );

  match_fsm u_match_fsm (
    .clk_out    (clk_out),
    .arst_n     (arst_n),
    .frame_tick (frame_tick),
    .pad1       (pad1),
    .pad2       (pad2),
    .stocks1    (stocks1),
    .stocks2    (stocks2),
    .game_state (game_state),
    .game_start (game_start),
    .play_tick  (play_tick)
  );

  // Box overlap doubles as the board's collision LED
  strike_judge u_strike_judge (
    .clk_out   (clk_out),
    .arst_n    (arst_n),
    .play_tick (play_tick),
    .pad1      (pad1),
    .pad2      (pad2),
    .p1_x      (p1_x),
    .p1_y      (p1_y),
    .p2_x      (p2_x),
    .p2_y      (p2_y),
    .stunned1  (stunned1),
    .stunned2  (stunned2),
    .hit1      (hit1),
    .hit2      (hit2),
    .overlap   (debug_collision)
  );

  fighter_health u_health1 (
    .clk_out    (clk_out),
    .arst_n     (arst_n),
    .play_tick  (play_tick),
    .game_start (game_start),
    .hit        (hit1),
    .damage     (damage1),
    .stocks     (stocks1),
    .stunned    (stunned1),
    .respawn    (respawn1)
  );

  fighter_health u_health2 (
    .clk_out    (clk_out),
    .arst_n     (arst_n),
    .play_tick  (play_tick),
    .game_start (game_start),
    .hit        (hit2),
    .damage     (damage2),
    .stocks     (stocks2),
    .stunned    (stunned2),
    .respawn    (respawn2)
  );

endmodule

// File: design/fighter_health.sv
`timescale 1ns/1ns
`include "match_defs.svh"

module fighter_health (
  input  logic                  clk_out,
  input  logic                  arst_n,
  input  logic                  play_tick,
  input  logic                  game_start,
  input  logic                  hit,
  output logic [`DAMAGE_W-1:0]  damage,
  output logic [`STOCK_W-1:0]   stocks,
  output logic                  stunned,
  output logic                  respawn
);

  localparam int STUN_W = $clog2(`HITSTUN_FRAMES + 1);
  localparam logic [STUN_W-1:0]    STUN_FULL   = `HITSTUN_FRAMES;
  localparam logic [STUN_W-1:0]    STUN_ONE    = 1;
  localparam logic [`DAMAGE_W-1:0] HIT_STEP    = `HIT_DAMAGE;
  localparam logic [`DAMAGE_W-1:0] LIMIT      = `DAMAGE_LIMIT;
  localparam logic [`STOCK_W-1:0]  STOCKS_FULL = `STOCKS_INIT;
  localparam logic [`STOCK_W-1:0]  STOCK_ONE   = 1;

  // Play ticks left in hit-stun
  logic [STUN_W-1:0]    stun_left;
  logic [`DAMAGE_W-1:0] damage_next;
  logic                 take_hit;
  logic                 lose_stock;

  // No more hits once the last stock is gone
  assign take_hit    = hit && (stocks != '0);
  assign damage_next = damage + HIT_STEP;
  assign lose_stock  = (damage_next >= LIMIT);

  always_ff @(posedge clk_out or negedge arst_n) begin
    if (!arst_n) begin
      damage    <= '0;
      stocks    <= STOCKS_FULL;
      stunned   <= 1'b0;
      stun_left <= '0;
      respawn   <= 1'b0;
    end else begin
      respawn <= 1'b0;
      if (game_start) begin
        damage    <= '0;
        stocks    <= STOCKS_FULL;
        stunned   <= 1'b0;
        stun_left <= '0;
        respawn   <= 1'b1;
      end else if (take_hit) begin
        stunned   <= 1'b1;
        stun_left <= STUN_FULL;
        if (lose_stock) begin
          // Knocked out, trade a stock for a fresh start
          damage  <= '0;
          stocks  <= stocks - STOCK_ONE;
          respawn <= 1'b1;
        end else begin
          damage <= damage_next;
        end
      end else if (play_tick && stunned) begin
        stun_left <= stun_left - STUN_ONE;
        if (stun_left == STUN_ONE) begin
          stunned <= 1'b0;
        end
      end
    end
  end

  stocks_bounded: assert property (
    @(posedge clk_out) disable iff (!arst_n)
    stocks <= STOCKS_FULL
  ) else $error("fighter_health: stocks above the starting count");

endmodule

// File: design/strike_judge.sv
`timescale 1ns/1ns
`include "match_defs.svh"

module strike_judge (
  input  logic               clk_out,
  input  logic               arst_n,
  input  logic               play_tick,
  input  pad_pkg::pad_word_t pad1,
  input  pad_pkg::pad_word_t pad2,
  input  logic [`POS_W-1:0]  p1_x,
  input  logic [`POS_W-1:0]  p1_y,
  input  logic [`POS_W-1:0]  p2_x,
  input  logic [`POS_W-1:0]  p2_y,
  input  logic               stunned1,
  input  logic               stunned2,
  output logic               hit1,
  output logic               hit2,
  output logic               overlap
);

  // One spare bit so box edges near the screen limit do not wrap
  localparam int EXT_W = `POS_W + 1;
  localparam logic [EXT_W-1:0] NEAR_W = `HITBOX_NEAR_W;
  localparam logic [EXT_W-1:0] FAR_W  = `HITBOX_FAR_W;
  localparam logic [EXT_W-1:0] NEAR_H = `HITBOX_NEAR_H;
  localparam logic [EXT_W-1:0] FAR_H  = `HITBOX_FAR_H;

  logic [EXT_W-1:0] x1;
  logic [EXT_W-1:0] y1;
  logic [EXT_W-1:0] x2;
  logic [EXT_W-1:0] y2;
  logic             a1_now;
  logic             a2_now;
  logic             a1_prev;
  logic             a2_prev;
  logic             fresh1;
  logic             fresh2;

  assign x1 = {1'b0, p1_x};
  assign y1 = {1'b0, p1_y};
  assign x2 = {1'b0, p2_x};
  assign y2 = {1'b0, p2_y};

  assign overlap = (x1 < x2 + FAR_W) && (x1 + NEAR_W > x2) &&
                   (y1 < y2 + FAR_H) && (y1 + NEAR_H > y2);

  assign a1_now = !pad1.fields.a_n;
  assign a2_now = !pad2.fields.a_n;

  // A state as seen at the previous play tick
  always_ff @(posedge clk_out or negedge arst_n) begin
    if (!arst_n) begin
      a1_prev <= 1'b0;
      a2_prev <= 1'b0;
    end else if (play_tick) begin
      a1_prev <= a1_now;
      a2_prev <= a2_now;
    end
  end

  assign fresh1 = a1_now && !a1_prev;
  assign fresh2 = a2_now && !a2_prev;

  // Player 2's attack lands on player 1 and the other way round
  assign hit1 = play_tick && fresh2 && overlap && !stunned1;
  assign hit2 = play_tick && fresh1 && overlap && !stunned2;

endmodule

// File: design/match_fsm.sv
`timescale 1ns/1ns
`include "match_defs.svh"

module match_fsm (
  input  logic                   clk_out,
  input  logic                   arst_n,
  input  logic                   frame_tick,
  input  pad_pkg::pad_word_t     pad1,
  input  pad_pkg::pad_word_t     pad2,
  input  logic [`STOCK_W-1:0]    stocks1,
  input  logic [`STOCK_W-1:0]    stocks2,
  output match_pkg::game_state_t game_state,
  output logic                   game_start,
  output logic                   play_tick
);

  logic                   start_ok1;
  logic                   start_ok2;
  logic                   start_req;
  logic                   playing;
  logic                   knocked_out;
  match_pkg::game_state_t next_state;

  // An all-zero word is a missing pad, not every button held
  assign start_ok1 = !pad1.fields.start_n && (pad1.raw != 8'h00);
  assign start_ok2 = !pad2.fields.start_n && (pad2.raw != 8'h00);
  assign start_req = start_ok1 || start_ok2;

  assign playing     = (game_state == match_pkg::STATE_PLAYING);
  assign knocked_out = (stocks1 == '0) || (stocks2 == '0);

  always_comb begin
    next_state = game_state;
    case (game_state)
      match_pkg::STATE_START_SCREEN,
      match_pkg::STATE_GAME_OVER: begin
        if (start_req) begin
          next_state = match_pkg::STATE_PLAYING;
        end
      end
      match_pkg::STATE_PLAYING: begin
        if (knocked_out) begin
          next_state = match_pkg::STATE_GAME_OVER;
        end
      end
      default: next_state = match_pkg::STATE_START_SCREEN;
    endcase
  end

  always_ff @(posedge clk_out or negedge arst_n) begin
    if (!arst_n) begin
      game_state <= match_pkg::STATE_START_SCREEN;
    end else begin
      game_state <= next_state;
    end
  end

  // High in the last cycle before play begins
  assign game_start = !playing && start_req;
  // Frames outside play are dropped so the fight freezes
  assign play_tick  = frame_tick && playing;

  state_legal: assert property (
    @(posedge clk_out) disable iff (!arst_n)
    game_state inside {match_pkg::STATE_START_SCREEN,
                       match_pkg::STATE_PLAYING,
                       match_pkg::STATE_GAME_OVER}
  ) else $error("match_fsm: unused state encoding");

endmodule

// File: design/pad_reader.sv
`timescale 1ns/1ns
`include "match_defs.svh"

module pad_reader (
  input  logic               clk_out,
  input  logic               arst_n,
  input  logic               data,
  output logic               latch,
  output logic               ctrl_clk,
  output pad_pkg::pad_word_t pad
);

  localparam int PHASE_W = $clog2(`PAD_HALF_PERIOD);
  localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`PAD_HALF_PERIOD - 1);
  localparam logic [PHASE_W-1:0] PHASE_ONE = PHASE_W'(1);

  // Position inside the current half period
  logic [PHASE_W-1:0] phase_cnt;
  // Step 0 is latch, even steps 2..14 are clock high, odd steps are low
  logic [3:0]         step_cnt;
  logic [2:0]         bit_idx;
  logic               half_done;
  logic               sample;
  // First seven bits of the poll in progress
  logic [6:0]         shift_q;

  assign bit_idx   = step_cnt[3:1];
  assign half_done = (phase_cnt == PHASE_LAST);
  // Sample on the falling edge of latch or of each clock pulse
  assign sample    = half_done && !step_cnt[0];

  assign latch    = (step_cnt == 4'd0);
  assign ctrl_clk = !step_cnt[0] && (step_cnt != 4'd0);

  // Starts in the last low step so the first poll follows one half period later
  always_ff @(posedge clk_out or negedge arst_n) begin
    if (!arst_n) begin
      phase_cnt <= '0;
      step_cnt  <= 4'd15;
    end else if (half_done) begin
      phase_cnt <= '0;
      step_cnt  <= step_cnt + 4'd1;
    end else begin
      phase_cnt <= phase_cnt + PHASE_ONE;
    end
  end

  always_ff @(posedge clk_out) begin
    if (sample) begin
      shift_q <= {shift_q[5:0], data};
    end
  end

  // Whole byte at once after the eighth bit
  always_ff @(posedge clk_out or negedge arst_n) begin
    if (!arst_n) begin
      pad.raw <= 8'hFF;
    end else if (sample && (bit_idx == 3'd7)) begin
      pad.raw <= {shift_q, data};
    end
  end

  // Latch is one half period wide and the clock is still low as it falls
  latch_pulse_width: assert property (
    @(posedge clk_out) disable iff (!arst_n)
    $fell(latch) |-> !ctrl_clk && $past(latch, `PAD_HALF_PERIOD) &&
                     !$past(latch, `PAD_HALF_PERIOD + 1)
  ) else $error("pad_reader: latch pulse of wrong width or overlapping ctrl_clk");

endmodule

// File: design/match_pkg.sv
package match_pkg;

  // Top-level match flow
  // Encoding 2'b11 is never used
  typedef enum logic [1:0] {
    STATE_START_SCREEN = 2'd0,
    STATE_PLAYING      = 2'd1,
    STATE_GAME_OVER    = 2'd2
  } game_state_t;

endpackage

// File: design/pad_pkg.sv
package pad_pkg;

  // One NES pad byte, all buttons active low
  // A is shifted in first and ends up in the MSB
  typedef struct packed {
    logic a_n;
    logic b_n;
    logic select_n;
    logic start_n;
    logic up_n;
    logic down_n;
    logic left_n;
    logic right_n;
  } pad_fields_t;

  // Raw view catches the all-zero word of a missing pad
  typedef union packed {
    logic [7:0]  raw;
    pad_fields_t fields;
  } pad_word_t;

endpackage

// File: design/match_defs.svh
`ifndef MATCH_DEFS_SVH
`define MATCH_DEFS_SVH

// Datapath widths
`define POS_W 11
`define DAMAGE_W 10
`define STOCK_W 2

// Damage rules
`define HIT_DAMAGE 12
`define DAMAGE_LIMIT 100
`define STOCKS_INIT 3

// Hit-stun length in frames
`define HITSTUN_FRAMES 4

// Overlap box, wider and taller on the opponent's side
`define HITBOX_NEAR_W 46
`define HITBOX_FAR_W 60
`define HITBOX_NEAR_H 60
`define HITBOX_FAR_H 80

// Pad latch and clock half period, in clk_out cycles
`define PAD_HALF_PERIOD 6

`endif
